// ==== verification/acquire_cases.txt ====
# name samples start(hex) stride(hex) gap max_ack_delay stall exp_words exp_overflow
# sample k = start + k*stride mod 2**24, gap and delay in cycles, blocks are 16 words
single_block        16  000100  000001   0  0  0  16  0
three_blocks        48  a50000  010203   9  2  0  48  0
partial_block       24  123456  000011   9  1  0  16  0
partial_complete     8  fff000  000100   3  1  0  16  0
stall_three_blocks  48  400000  000007   0  1  1  32  1
refill_after_ovf    32  800001  fffffd   9  2  0  32  1
sparse_slow_ack     32  0abcde  031415  12  3  0  32  1

// ==== acquire_top.f ====
+incdir+verification
design/acq_pkg.sv
design/block_buffer.sv
design/block_writer.sv
design/block_drainer.sv
design/acquire_top.sv
verification/tb_acquire_top.sv

// ==== verification/tb_acquire_checks.svh ====
`ifndef TB_ACQUIRE_CHECKS_SVH
`define TB_ACQUIRE_CHECKS_SVH

// ----------------------------------------
// Result bookkeeping
// ----------------------------------------

int test_errs = 0;                            // Errors since the last closed test
int check_cnt = 0;                            // Compares over the whole run
int pass_cnt  = 0;
int fail_cnt  = 0;

// DRAM word payload
task automatic check_sample(input string name, input sample_t got, input sample_t exp);
   check_cnt++;
   if (got !== exp) begin
      $display("[FAIL] %s got %06h expected %06h", name, got, exp);
      test_errs++;
   end
endtask

// DRAM word address, block count over index
task automatic check_addr(input string name, input dram_addr_t got, input dram_addr_t exp);
   check_cnt++;
   if (got !== exp) begin
      $display("[FAIL] %s got %06h expected %06h", name, got, exp);
      test_errs++;
   end
endtask

// Single status bit such as overflow
task automatic check_flag(input string name, input logic got, input logic exp);
   check_cnt++;
   if (got !== exp) begin
      $display("[FAIL] %s got %0h expected %0h", name, got, exp);
      test_errs++;
   end
endtask

// Failures that carry no value pair
task automatic note_error(input string msg);
   $display("%s", msg);
   test_errs++;
endtask

// One summary line per test, then clear the error count
task automatic close_test(input string name, input int words, input int exp_words);
   if (test_errs == 0) begin
      pass_cnt++;
      $display("%-20s words %0d/%0d  ok", name, words, exp_words);
   end else begin
      fail_cnt++;
      $display("%-20s words %0d/%0d  %0d errors", name, words, exp_words, test_errs);
   end
   test_errs = 0;
endtask

`endif

// ==== verification/tb_acquire_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_acquire_top;

   import acq_pkg::*;

   localparam int    ABITS     = 4;                       // 16 words per block
   localparam int    BLOCK     = 1 << ABITS;
   localparam string CASE_FILE = "verification/acquire_cases.txt";

   logic       clk;
   logic       rst;
   logic       sample_valid;
   sample_t    sample_data;
   logic       dram_ack;
   logic       dram_req;
   sample_t    dram_data;
   dram_addr_t dram_addr;
   logic       overflow;

   // Case table, one entry per file line
   string   c_name   [$];
   int      c_count  [$];
   sample_t c_start  [$];
   sample_t c_stride [$];
   int      c_gap    [$];
   int      c_delay  [$];
   bit      c_stall  [$];
   int      c_words  [$];
   logic    c_ov     [$];

   // Reference model
   sample_t exp_q   [$];                                  // Stored samples in DRAM order
   sample_t blk_buf [$];                                  // Samples of the open block
   int      held;                                         // Full blocks not yet drained
   bit      drop;                                         // Both banks full
   int      word_cnt;                                     // Running DRAM word count
   int      test_words;                                   // Words seen in this test

   int      max_delay;                                    // Responder delay limit
   bit      stall;                                        // Hold ack off while sending
   int      seed;
   int      cycle_cnt;
   int      cycle_limit;

   `include "tb_acquire_checks.svh"

   acquire_top #(.ABITS(ABITS)) i_acquire_top (
      .clk          (clk),
      .rst          (rst),
      .sample_valid (sample_valid),
      .sample_data  (sample_data),
      .dram_ack     (dram_ack),
      .dram_req     (dram_req),
      .dram_data    (dram_data),
      .dram_addr    (dram_addr),
      .overflow     (overflow)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                              // 4 ns period
   end

   // ----------------------------------------
   // Case file and model
   // ----------------------------------------

   task automatic read_cases();
      int    fd;
      int    got;
      int    n, g, d, st, w, ov;
      int    s0, sd;
      string line;
      string name;
      fd = $fopen(CASE_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open case file %s", CASE_FILE);
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            got = $sscanf(line, "%s %d %h %h %d %d %d %d %d", name, n, s0, sd, g, d, st, w, ov);
            if (line.len() > 0 && line.substr(0, 0) == "#") begin
               continue;                                  // Column legend
            end
            if (got == 9) begin
               c_name.push_back(name);
               c_count.push_back(n);
               c_start.push_back(sample_t'(s0));
               c_stride.push_back(sample_t'(sd));
               c_gap.push_back(g);
               c_delay.push_back(d);
               c_stall.push_back(st != 0);
               c_words.push_back(w);
               c_ov.push_back(ov != 0);
            end else if (got > 0) begin
               $display("Skipping malformed case line: %s", line);
            end
         end
         $fclose(fd);
      end
   endtask

   // Writer rule, full blocks only, nothing kept while both banks are full
   task automatic model_sample(input sample_t s);
      if (!drop) begin
         blk_buf.push_back(s);
         if (blk_buf.size() == BLOCK) begin
            while (blk_buf.size() > 0) exp_q.push_back(blk_buf.pop_front());
            held++;
            if (held == 2) drop = 1'b1;                   // Next bank still draining
         end
      end
   endtask

   task automatic send_samples(input int i);
      sample_t s;
      for (int k = 0; k < c_count[i]; k++) begin
         s = sample_t'(c_start[i] + k * c_stride[i]);     // Wraps modulo 2**24
         @(posedge clk);
         sample_valid <= 1'b1;
         sample_data  <= s;
         model_sample(s);
         repeat (c_gap[i]) begin
            @(posedge clk);
            sample_valid <= 1'b0;
         end
      end
      @(posedge clk);
      sample_valid <= 1'b0;
   endtask

   task automatic run_test(input int i);
      int waited;
      int wait_limit;
      waited     = 0;
      wait_limit = c_count[i] * (c_gap[i] + 2 * c_delay[i] + 6) + 200;
      test_words = 0;
      max_delay  = c_delay[i];
      stall      = c_stall[i];
      send_samples(i);
      stall = 1'b0;                                       // Let the drain resume
      while (test_words < c_words[i] && waited < wait_limit) begin
         @(posedge clk);
         waited++;
      end
      while (dram_ack) @(posedge clk);                    // Last handshake closes
      repeat (4) @(posedge clk);                          // Busy bit release
      if (test_words != c_words[i]) begin
         note_error($sformatf("%s: received %0d DRAM words but %0d were due",
                              c_name[i], test_words, c_words[i]));
      end
      if (exp_q.size() != 0) begin
         note_error($sformatf("%s: %0d stored samples never reached DRAM",
                              c_name[i], exp_q.size()));
      end
      check_flag("overflow", overflow, c_ov[i]);
      close_test(c_name[i], test_words, c_words[i]);
   endtask

   // ----------------------------------------
   // DRAM side
   // ----------------------------------------

   // Four-phase sink with random delay on both edges
   initial begin : ack_responder
      int d;
      forever begin
         @(posedge clk);
         if (!rst && dram_req && !stall) begin
            d = $unsigned($random(seed)) % (max_delay + 1);
            repeat (d) @(posedge clk);
            dram_ack <= 1'b1;
            do @(posedge clk); while (dram_req);          // Wait for req release
            d = $unsigned($random(seed)) % (max_delay + 1);
            repeat (d) @(posedge clk);
            dram_ack <= 1'b0;
         end
      end
   end

   task automatic take_word();
      if (exp_q.size() == 0) begin
         note_error($sformatf("DRAM word %06h at %06h arrived with nothing stored",
                              dram_data, dram_addr));
      end else begin
         check_sample("dram_data", dram_data, exp_q.pop_front());
      end
      check_addr("dram_addr", dram_addr, dram_addr_t'(word_cnt));
      word_cnt++;
      test_words++;
      if (word_cnt % BLOCK == 0) begin
         held--;                                          // Block handed over
         if (held < 2) drop = 1'b0;
      end
   endtask

   // Req and ack overlap for exactly one edge per word
   always @(posedge clk) begin
      if (!rst && dram_req && dram_ack) take_word();
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
         $display("Run stopped after %0d cycles with DRAM words still missing", cycle_limit);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------

   initial begin : main
      int total;
      rst          = 1'b1;
      sample_valid = 1'b0;
      sample_data  = '0;
      dram_ack     = 1'b0;
      stall        = 1'b0;
      max_delay    = 0;
      held         = 0;
      drop         = 1'b0;
      word_cnt     = 0;
      test_words   = 0;
      cycle_cnt    = 0;
      cycle_limit  = 0;
      seed         = 32'h56edf301;
      total        = 0;
      read_cases();
      if (c_name.size() == 0) begin
         $display("No test cases loaded");
         $display("TEST RESULT: FAIL");
         $finish;
      end else begin
         foreach (c_count[i]) total += c_count[i] * (c_gap[i] + 2 * c_delay[i] + 6);
         cycle_limit = total + 200;
         repeat (4) @(posedge clk);
         rst <= 1'b0;
         @(posedge clk);
         foreach (c_name[i]) run_test(i);                 // No reset between tests
         $display("Tests passed %0d, failed %0d, checks %0d", pass_cnt, fail_cnt, check_cnt);
         if (fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
         end else begin
            $display("TEST RESULT: FAIL");
         end
         $finish;
      end
   end

endmodule : tb_acquire_top

`default_nettype wire

// ==== design/acquire_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// Acquisition buffer, ping-pong blocks between the sample stream
// and the DRAM write port
module acquire_top #(
   parameter int ABITS = 9                    // Block address width, 2**ABITS words
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                sample_valid,
   input  acq_pkg::sample_t    sample_data,
   input  logic                dram_ack,
   output logic                dram_req,
   output acq_pkg::sample_t    dram_data,
   output acq_pkg::dram_addr_t dram_addr,
   output logic                overflow
);

   import acq_pkg::*;

   // ----------------------------------------
   // Internal nets
   // ----------------------------------------

   logic             wr_en_a;                 // Writer to bank A
   logic             wr_en_b;                 // Writer to bank B
   logic [ABITS-1:0] wr_addr;
   sample_t          wr_data;
   logic             block_done;              // Writer to drainer
   bank_t            done_bank;
   logic [1:0]       bank_busy;               // Drainer to writer
   logic [ABITS-1:0] rd_addr;                 // Drainer to both banks
   sample_t          rd_data_a;
   sample_t          rd_data_b;

   // ----------------------------------------
   // Instances
   // ----------------------------------------

   block_writer #(.ABITS(ABITS)) i_block_writer (
      .clk          (clk),
      .rst          (rst),
      .sample_valid (sample_valid),
      .sample_data  (sample_data),
      .bank_busy    (bank_busy),
      .wr_en_a      (wr_en_a),
      .wr_en_b      (wr_en_b),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .block_done   (block_done),
      .done_bank    (done_bank),
      .overflow     (overflow)
   );

   block_buffer #(.ABITS(ABITS)) bank_a (
      .clk     (clk),
      .wr_en   (wr_en_a),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data_a)
   );

   block_buffer #(.ABITS(ABITS)) bank_b (
      .clk     (clk),
      .wr_en   (wr_en_b),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data_b)
   );

   block_drainer #(.ABITS(ABITS)) i_block_drainer (
      .clk        (clk),
      .rst        (rst),
      .block_done (block_done),
      .done_bank  (done_bank),
      .rd_data_a  (rd_data_a),
      .rd_data_b  (rd_data_b),
      .dram_ack   (dram_ack),
      .rd_addr    (rd_addr),
      .bank_busy  (bank_busy),
      .dram_req   (dram_req),
      .dram_data  (dram_data),
      .dram_addr  (dram_addr)
   );

endmodule : acquire_top

`default_nettype wire

// ==== design/block_drainer.sv ====
`timescale 1ns/10ps
`default_nettype none

// Drains completed blocks from the two banks, in completion order,
// one word per four-phase req/ack exchange with the DRAM port.
module block_drainer #(
   parameter int ABITS = 9                    // Block address width
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                block_done,    // Writer finished a block
   input  acq_pkg::bank_t      done_bank,     // Which bank finished
   input  acq_pkg::sample_t    rd_data_a,     // Bank A read word
   input  acq_pkg::sample_t    rd_data_b,     // Bank B read word
   input  logic                dram_ack,
   output logic [ABITS-1:0]    rd_addr,       // Shared read index
   output logic [1:0]          bank_busy,     // One bit per bank
   output logic                dram_req,
   output acq_pkg::sample_t    dram_data,
   output acq_pkg::dram_addr_t dram_addr
);

   import acq_pkg::*;

   localparam int CNT_BITS = $bits(dram_addr_t) - ABITS; // Block counter width

   typedef logic [ABITS-1:0]    baddr_t;
   typedef logic [CNT_BITS-1:0] blk_cnt_t;

   // ----------------------------------------
   // State
   // ----------------------------------------

   drain_state_t state;
   bank_t        cur_bank;                    // Bank being drained
   baddr_t       rd_idx;                      // In-block read index
   blk_cnt_t     blk_cnt;                     // Upper DRAM address bits
   logic         pend_valid;                  // One queued block
   bank_t        pend_bank;
   sample_t      rd_word;                     // Word of the current bank
   logic         finish;                      // Last word's ack released
   logic         take_done;                   // Start on the new block now
   logic         queue_done;                  // Park the new block

   assign rd_addr = rd_idx;                   // Both banks read in parallel
   assign rd_word = (cur_bank == BANK_A) ? rd_data_a : rd_data_b;

   // Index is bumped at ack rise, so 0 here means the block wrapped
   assign finish = (state == DRN_WAIT_ACK_LOW) && !dram_ack && (rd_idx == '0);

   assign take_done  = block_done && ((state == DRN_IDLE) || (finish && !pend_valid));
   assign queue_done = block_done && !take_done;

   // ----------------------------------------
   // FSM and control
   // ----------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= DRN_IDLE;
         cur_bank   <= BANK_A;
         rd_idx     <= '0;
         blk_cnt    <= '0;
         pend_valid <= 1'b0;
         bank_busy  <= 2'b00;
         dram_req   <= 1'b0;
      end else begin
         case (state)
            DRN_IDLE: begin
               if (take_done) begin
                  cur_bank <= done_bank;      // Word 0 already on rd_data next cycle
                  state    <= DRN_READ;
               end
            end
            DRN_READ: begin
               dram_req <= 1'b1;              // Word captured in the payload block
               state    <= DRN_REQ;
            end
            DRN_REQ: begin
               if (dram_ack) begin
                  dram_req <= 1'b0;
                  rd_idx   <= rd_idx + 1'b1;  // Prefetch next word during release
                  state    <= DRN_WAIT_ACK_LOW;
               end
            end
            DRN_WAIT_ACK_LOW: begin
               if (!dram_ack) begin
                  if (!finish) begin
                     state <= DRN_READ;
                  end else begin
                     blk_cnt             <= blk_cnt + 1'b1;
                     bank_busy[cur_bank] <= 1'b0; // Writer may refill it
                     if (pend_valid) begin
                        cur_bank   <= pend_bank;
                        pend_valid <= 1'b0;
                        state      <= DRN_READ;
                     end else if (take_done) begin
                        cur_bank <= done_bank;
                        state    <= DRN_READ;
                     end else begin
                        state <= DRN_IDLE;
                     end
                  end
               end
            end
            default: state <= DRN_IDLE;
         endcase

         if (block_done) begin
            bank_busy[done_bank] <= 1'b1;     // Never the bank being released
         end
         if (queue_done) begin
            pend_valid <= 1'b1;
         end
      end
   end

   // ----------------------------------------
   // Payload registers
   // ----------------------------------------

   always_ff @(posedge clk) begin
      if (state == DRN_READ) begin
         dram_data <= rd_word;
         dram_addr <= {blk_cnt, rd_idx};      // Block count over index
      end
      if (queue_done) begin
         pend_bank <= done_bank;
      end
   end

   // ----------------------------------------
   // Checks
   // ----------------------------------------

   // Word and address held for the whole request
   a_req_stable: assert property (
      @(posedge clk) disable iff (rst)
      (dram_req && $past(dram_req)) |-> ($stable(dram_data) && $stable(dram_addr))
   ) else $error("block_drainer: DRAM word changed under req");

   // Four-phase rule, sink must have released ack first
   a_req_after_ack_low: assert property (
      @(posedge clk) disable iff (rst) $rose(dram_req) |-> !dram_ack
   ) else $error("block_drainer: req raised while ack high");

   // Writer never completes a third block
   a_pend_overrun: assert property (
      @(posedge clk) disable iff (rst) !(queue_done && pend_valid)
   );

endmodule : block_drainer

`default_nettype wire

// ==== design/block_writer.sv ====
`timescale 1ns/10ps
`default_nettype none

// Packs the incoming sample stream into blocks, alternating between
// bank A and bank B. Drops samples while the next bank is still draining.
module block_writer #(
   parameter int ABITS = 9                    // Block address width
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              sample_valid,    // One strobe per sample
   input  acq_pkg::sample_t  sample_data,
   input  logic [1:0]        bank_busy,       // Owned by the drainer
   output logic              wr_en_a,         // Bank A write strobe
   output logic              wr_en_b,         // Bank B write strobe
   output logic [ABITS-1:0]  wr_addr,         // Shared write index
   output acq_pkg::sample_t  wr_data,         // Shared write word
   output logic              block_done,      // Last word of a block written
   output acq_pkg::bank_t    done_bank,       // Bank that just completed
   output logic              overflow         // Sticky, a sample was lost
);

   import acq_pkg::*;

   typedef logic [ABITS-1:0] baddr_t;

   // ----------------------------------------
   // State
   // ----------------------------------------

   bank_t  cur_bank;                          // Bank being filled
   bank_t  next_bank;                         // Bank to use after the wrap
   baddr_t wr_idx;                            // In-block write index
   logic   drop;                              // Drop mode flag
   logic   in_drop;                           // Drop mode and bank still busy
   logic   accept;                            // Sample goes into the RAM
   logic   last_word;                         // Index at end of block

   assign next_bank = ~cur_bank;
   assign in_drop   = drop && bank_busy[cur_bank]; // Bank freed this cycle takes the sample
   assign accept    = sample_valid && !in_drop;
   assign last_word = (wr_idx == {ABITS{1'b1}});

   // ----------------------------------------
   // Bank write port, zero latency
   // ----------------------------------------

   assign wr_en_a    = accept && (cur_bank == BANK_A);
   assign wr_en_b    = accept && (cur_bank == BANK_B);
   assign wr_addr    = wr_idx;
   assign wr_data    = sample_data;           // Written in the strobe cycle

   assign block_done = accept && last_word;   // One cycle, with the last write
   assign done_bank  = cur_bank;

   // ----------------------------------------
   // Index, bank switch and drop mode
   // ----------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         cur_bank <= BANK_A;
         wr_idx   <= '0;
         drop     <= 1'b0;
         overflow <= 1'b0;
      end else begin
         if (drop && !bank_busy[cur_bank]) begin
            drop <= 1'b0;                     // Drainer released the bank
         end

         if (accept) begin
            wr_idx <= wr_idx + 1'b1;          // Wraps to 0 at block end
            if (last_word) begin
               cur_bank <= next_bank;         // Takes effect on next sample
               drop     <= bank_busy[next_bank]; // Next bank still draining
            end
         end

         if (sample_valid && in_drop) begin
            overflow <= 1'b1;                 // Sticky until reset
         end
      end
   end

   // ----------------------------------------
   // Checks
   // ----------------------------------------

   // Only one bank written per cycle
   a_one_bank: assert property (
      @(posedge clk) disable iff (rst) !(wr_en_a && wr_en_b)
   );

   // Never write into a block the drainer still owns
   a_no_write_busy_a: assert property (
      @(posedge clk) disable iff (rst) wr_en_a |-> !bank_busy[BANK_A]
   ) else $error("block_writer: write to busy bank A");

   a_no_write_busy_b: assert property (
      @(posedge clk) disable iff (rst) wr_en_b |-> !bank_busy[BANK_B]
   ) else $error("block_writer: write to busy bank B");

endmodule : block_writer

`default_nettype wire

// ==== design/block_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

// One block of samples in a simple dual-port RAM.
// Write port is fed by the writer, read port by the drainer.
module block_buffer #(
   parameter int ABITS = 9                    // Block address width
) (
   input  logic              clk,
   input  logic              wr_en,           // Write strobe from the writer
   input  logic [ABITS-1:0]  wr_addr,         // In-block write index
   input  acq_pkg::sample_t  wr_data,         // Sample to store
   input  logic [ABITS-1:0]  rd_addr,         // In-block read index
   output acq_pkg::sample_t  rd_data          // Registered read word
);

   import acq_pkg::*;

   localparam int DEPTH = 1 << ABITS;         // Words per block

   // ----------------------------------------
   // Storage
   // ----------------------------------------

   sample_t mem [DEPTH];                      // Inferred block RAM

   // Write port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;             // Same cycle as the strobe
      end
   end

   // Read port, one cycle latency
   // A write lands in mem at the edge, so a read of that address
   // on the following cycle already sees the new word
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

   // ----------------------------------------
   // Checks
   // ----------------------------------------

   // Writer must present a known word with every strobe
   a_wr_data_known: assert property (
      @(posedge clk) wr_en |-> !$isunknown({wr_addr, wr_data})
   ) else $error("block_buffer: unknown write at index %0h", wr_addr);

endmodule : block_buffer

`default_nettype wire

// ==== design/acq_pkg.sv ====
`default_nettype none

package acq_pkg;

   // ----------------------------------------
   // Sample path types
   // ----------------------------------------

   typedef logic [23:0] sample_t;     // Raw antenna sample word

   typedef logic        bank_t;       // 0 selects bank A, 1 selects bank B

   localparam bank_t BANK_A = 1'b0;   // First bank after reset
   localparam bank_t BANK_B = 1'b1;

   // ----------------------------------------
   // DRAM side types
   // ----------------------------------------

   // Block count in the upper bits, in-block index in the lower bits
   typedef logic [23:0] dram_addr_t;

   // Drainer FSM
   typedef enum logic [1:0] {
      DRN_IDLE,                       // No block to drain
      DRN_READ,                       // RAM word is valid, capture it
      DRN_REQ,                        // Request high, wait for ack
      DRN_WAIT_ACK_LOW                // Request dropped, wait for ack release
   } drain_state_t;

endpackage : acq_pkg

`default_nettype wire
